//--- sim/openflow_switch_checker.sv
`timescale 1ns/100ps

module openflow_switch_checker
   import of_switch_pkg::*;
(
   input logic                 clk,
   input logic                 rst_n,
   input logic [num_ports-1:0] out_wr,
   input logic [num_ports-1:0] out_rdy,
   input logic                 psel,
   input logic                 penable,
   input logic                 pready
);

   // Egress writes only toward ready ports
   a_out_wr_rdy: assert property (@(posedge clk) disable iff (!rst_n)
      (out_wr & ~out_rdy) == '0)
      else $error("out_wr high on a port whose out_rdy is low");

   // No wait states on APB
   a_pready: assert property (@(posedge clk) disable iff (!rst_n)
      (psel && penable) |-> pready)
      else $error("pready low in an APB access phase");

   // Egress quiet in reset
   a_reset_quiet: assert property (@(posedge clk) !rst_n |-> (out_wr == '0))
      else $error("out_wr high while rst_n is low");

endmodule

bind openflow_switch openflow_switch_checker u_checker (.*);

//--- sim/openflow_switch_tb.sv
`timescale 1ns/100ps

module openflow_switch_tb
   import of_switch_pkg::*;
;

   localparam int drain_timeout = 5000;
   localparam int apb_timeout   = 16;
   localparam int word_bits     = ctrl_width + data_width;

   logic                      clk;
   logic                      rst_n;
   word_t                     in_data [num_ports];
   ctrl_t                     in_ctrl [num_ports];
   logic [num_ports-1:0]      in_wr;
   logic [num_ports-1:0]      in_rdy;
   word_t                     out_data [num_ports];
   ctrl_t                     out_ctrl [num_ports];
   logic [num_ports-1:0]      out_wr;
   logic [num_ports-1:0]      out_rdy;
   logic [apb_addr_width-1:0] paddr;
   logic                      psel;
   logic                      penable;
   logic                      pwrite;
   logic [apb_data_width-1:0] pwdata;
   logic [apb_data_width-1:0] prdata;
   logic                      pready;
   logic                      pslverr;

   // Words still to send and words still awaited, as {ctrl, data}
   logic [word_bits-1:0] in_q  [num_ports][$];
   logic [word_bits-1:0] exp_q [num_ports][$];

   openflow_switch uut (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   // Random back-pressure on the egress ports
   initial begin
      void'($urandom(32'ha533));
      out_rdy = '0;
      forever begin
         @(posedge clk);
         if (rst_n) begin
            for (int p = 0; p < num_ports; p++)
               out_rdy[p] <= ($urandom % 4) != 0;
         end
      end
   end

   // ------------------------------------------------------------------------
   // Checking helpers
   // ------------------------------------------------------------------------
   task automatic stop_on_failure();
      $display("Simulation failed");
      $fatal(1, "run stopped at the first failure");
   endtask

   task automatic check_value(input string what, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("** Error at %0d ns: %s is %h, expected %h", $time, what, got, exp);
         stop_on_failure();
      end
   endtask

   function automatic logic traffic_idle();
      logic idle;
      idle = (in_wr == '0);
      for (int p = 0; p < num_ports; p++) begin
         if (in_q[p].size() != 0 || exp_q[p].size() != 0)
            idle = 1'b0;
      end
      return idle;
   endfunction

   task automatic wait_for_drain();
      int cycles;
      cycles = 0;
      while (!traffic_idle() && cycles < drain_timeout) begin
         @(negedge clk);
         cycles++;
      end
      if (!traffic_idle()) begin
         $display("Timeout: traffic did not drain within %0d cycles", drain_timeout);
         stop_on_failure();
      end
   endtask

   // One APB transfer, setup then access until pready
   task automatic apb_access(input logic wr, input logic [apb_addr_width-1:0] addr,
                             input logic [apb_data_width-1:0] data, input logic err);
      int cycles;
      cycles = 0;
      @(posedge clk);
      paddr   <= addr;
      pwrite  <= wr;
      pwdata  <= wr ? data : '0;
      psel    <= 1'b1;
      penable <= 1'b0;
      @(posedge clk);
      penable <= 1'b1;
      do begin
         @(posedge clk);
         cycles++;
      end while (!pready && cycles < apb_timeout);
      if (!pready) begin
         $display("Timeout: APB access to address %h never completed", addr);
         stop_on_failure();
      end else begin
         check_value($sformatf("pslverr at address %h", addr), 64'(pslverr), 64'(err));
         if (!wr)
            check_value($sformatf("prdata at address %h", addr), 64'(prdata), 64'(data));
         psel    <= 1'b0;
         penable <= 1'b0;
         @(negedge clk);
      end
   endtask

   // ------------------------------------------------------------------------
   // Ingress drivers and egress monitor
   // ------------------------------------------------------------------------
   always @(posedge clk) begin
      if (rst_n) begin
         for (int p = 0; p < num_ports; p++) begin
            if (in_wr[p] && in_rdy[p])
               void'(in_q[p].pop_front());
            if (in_q[p].size() != 0 && in_rdy[p]) begin
               in_wr[p]   <= 1'b1;
               in_ctrl[p] <= in_q[p][0][data_width +: ctrl_width];
               in_data[p] <= in_q[p][0][data_width-1:0];
            end else begin
               in_wr[p] <= 1'b0;
            end
         end
      end
   end

   always @(posedge clk) begin
      logic [word_bits-1:0] exp_word;
      if (rst_n) begin
         for (int p = 0; p < num_ports; p++) begin
            if (out_wr[p]) begin
               if (exp_q[p].size() == 0) begin
                  $display("Port %0d sent a word at %0d ns that was not expected", p, $time);
                  stop_on_failure();
               end else begin
                  exp_word = exp_q[p].pop_front();
                  check_value($sformatf("ctrl on port %0d", p), 64'(out_ctrl[p]),
                              64'(exp_word[data_width +: ctrl_width]));
                  check_value($sformatf("data on port %0d", p), out_data[p],
                              exp_word[data_width-1:0]);
               end
            end
         end
      end
   end

   // ------------------------------------------------------------------------
   // Vector sequencer
   // ------------------------------------------------------------------------
   initial begin
      int          fd;
      int          n;
      int          leftover;
      string       line;
      byte         cmd;
      logic [63:0] f1;
      logic [63:0] f2;
      logic [63:0] f3;
      rst_n   = 1'b0;
      in_wr   = '0;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      for (int p = 0; p < num_ports; p++) begin
         in_data[p] = '0;
         in_ctrl[p] = '0;
      end
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      // Every queue starts out empty
      check_value("in_rdy after reset", 64'(in_rdy), 64'({num_ports{1'b1}}));

      fd = $fopen("sim/switch_vectors.txt", "r");
      if (fd == 0) begin
         $display("Could not open the vector file sim/switch_vectors.txt");
         stop_on_failure();
      end else begin
         while (!$feof(fd)) begin
            line = "";
            cmd  = " ";
            n    = $fgets(line, fd);
            if (line.len() > 1 && line[0] != "#")
               n = $sscanf(line, "%c %h %h %h", cmd, f1, f2, f3);
            case (cmd)
               "W": apb_access(1'b1, f1[apb_addr_width-1:0], f2[31:0], f3[0]);
               "R": apb_access(1'b0, f1[apb_addr_width-1:0], f2[31:0], f3[0]);
               "I": in_q[f1[1:0]].push_back({f2[ctrl_width-1:0], f3});
               "E": exp_q[f1[1:0]].push_back({f2[ctrl_width-1:0], f3});
               "D": wait_for_drain();
               default: ;
            endcase
         end
         $fclose(fd);

         leftover = 0;
         for (int p = 0; p < num_ports; p++)
            leftover += exp_q[p].size() + in_q[p].size();
         if (leftover == 0) begin
            $display("Simulation passed");
            $finish;
         end else begin
            $display("%0d words were never sent or never arrived", leftover);
            stop_on_failure();
         end
      end
   end

endmodule

//--- sim/switch_vectors.txt
# W addr data err : APB write, expected pslverr / R addr data err : APB read, prdata and pslverr
# I port ctrl data : word into an input port / E port ctrl data : expected output word / D : drain
W 00 00000011 0
W 04 00000012 0
W 08 00000014 0
W 0c ffffff18 0
W 10 0000001d 0
W 14 00000005 0
W 18 00000010 0
W 40 00000007 1
W 02 00000011 1
R 04 00000012 0
R 0c 00000018 0
R 10 0000001d 0
R 14 00000005 0
R 18 00000010 0
R 40 00000000 0
R 48 00000000 1
# Unicast from port 1, tag 1, stale source and mask fields in the header
I 1 ff 123456780f030001
I 1 00 0000000000001111
I 1 01 aaaaaaaaaaaaaaaa
E 1 ff 1234567802010001
E 1 00 0000000000001111
E 1 01 aaaaaaaaaaaaaaaa
D
# Multicast from port 2, tag 4 to ports 0, 2 and 3
I 2 ff 0000000000000004
I 2 00 5555555555555555
I 2 40 6666666666666666
E 0 ff 000000000d020004
E 0 00 5555555555555555
E 0 40 6666666666666666
E 2 ff 000000000d020004
E 2 00 5555555555555555
E 2 40 6666666666666666
E 3 ff 000000000d020004
E 3 00 5555555555555555
E 3 40 6666666666666666
D
# Port 3, invalid entry, zero mask entry, then unicast tag 3
I 3 ff 0000000000000005
I 3 02 7777777777777777
I 3 ff 0000000000000006
I 3 02 8888888888888888
I 3 ff 0000000000000003
I 3 09 9999999999999999
E 3 ff 0000000008030003
E 3 09 9999999999999999
D
# All four inputs at once, ports 0 and 1 both aimed at output 0
I 0 ff a000000000000000
I 0 03 a0a0a0a0a0a0a0a0
I 0 ff b000000000000000
I 0 04 b1b1b1b1b1b1b1b1
I 1 ff c000000000000000
I 1 05 c1c1c1c1c1c1c1c1
I 2 ff d000000000000002
I 2 06 d1d1d1d1d1d1d1d1
I 3 ff e000000000000003
I 3 07 e1e1e1e1e1e1e1e1
E 0 ff a000000001000000
E 0 03 a0a0a0a0a0a0a0a0
E 0 ff c000000001010000
E 0 05 c1c1c1c1c1c1c1c1
E 0 ff b000000001000000
E 0 04 b1b1b1b1b1b1b1b1
E 2 ff d000000004020002
E 2 06 d1d1d1d1d1d1d1d1
E 3 ff e000000008030003
E 3 07 e1e1e1e1e1e1e1e1
D
R 40 00000008 0
R 44 00000002 0

//--- sources.f
verilog/of_switch_pkg.sv
verilog/input_queue.sv
verilog/input_arbiter.sv
verilog/flow_table.sv
verilog/output_port_lookup.sv
verilog/egress_demux.sv
verilog/openflow_switch.sv
sim/openflow_switch_checker.sv
sim/openflow_switch_tb.sv

//--- verilog/egress_demux.sv
`timescale 1ns/100ps

module egress_demux
   import of_switch_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  word_t                lut_data,
   input  ctrl_t                lut_ctrl,
   input  logic                 lut_wr,
   output logic                 demux_rdy,
   output word_t                out_data [num_ports],
   output ctrl_t                out_ctrl [num_ports],
   output logic [num_ports-1:0] out_wr,
   input  logic [num_ports-1:0] out_rdy
);

   word_t      o_data;
   ctrl_t      o_ctrl;
   port_mask_t o_mask;
   port_mask_t in_mask;
   logic       o_vld;
   logic       fire;

   // Header brings its own mask, the rest of the packet reuses it
   assign in_mask = (lut_ctrl == ctrl_hdr) ? lut_data[out_mask_lsb +: num_ports] : o_mask;

   // All masked ports must be ready at once
   assign fire      = o_vld && (&(out_rdy | ~o_mask));
   assign demux_rdy = !o_vld || fire;
   assign out_wr    = fire ? o_mask : '0;

   always_comb begin
      for (int i = 0; i < num_ports; i++) begin
         out_data[i] = o_data;
         out_ctrl[i] = o_ctrl;
      end
   end

   always_ff @(posedge clk) begin
      if (lut_wr) begin
         o_data <= lut_data;
         o_ctrl <= lut_ctrl;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         o_vld  <= 1'b0;
         o_mask <= '0;
      end else begin
         if (lut_wr) begin
            o_vld  <= 1'b1;
            o_mask <= in_mask;
         end else if (fire) begin
            o_vld <= 1'b0;
         end
      end
   end

endmodule

//--- verilog/flow_table.sv
`timescale 1ns/100ps

module flow_table
   import of_switch_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   input  logic [apb_addr_width-1:0] paddr,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [apb_data_width-1:0] pwdata,
   output logic [apb_data_width-1:0] prdata,
   output logic                      pready,
   output logic                      pslverr,
   input  flow_tag_t                 lookup_tag,
   output logic                      lookup_entry_valid,
   output port_mask_t                lookup_mask,
   input  logic                      count_hit,
   input  logic                      count_miss
);

   logic [table_depth-1:0]    entry_valid;
   port_mask_t                entry_mask [table_depth];
   logic [apb_data_width-1:0] hit_count;
   logic [apb_data_width-1:0] miss_count;

   logic      access;
   logic      is_entry;
   logic      is_hit;
   logic      is_miss;
   logic      entry_wr;
   flow_tag_t entry_idx;

   // ------------------------------------------------------------------------
   // Address decode
   // ------------------------------------------------------------------------
   assign access    = psel && penable;
   assign is_entry  = (paddr <= entry_last_addr) && (paddr[1:0] == 2'b00);
   assign is_hit    = (paddr == hit_count_addr);
   assign is_miss   = (paddr == miss_count_addr);
   assign entry_idx = paddr[2 +: flow_tag_width];
   assign entry_wr  = access && pwrite && is_entry;

   // No wait states
   assign pready  = 1'b1;
   // Counters are read only
   assign pslverr = access && (!(is_entry || is_hit || is_miss) ||
                               (pwrite && (is_hit || is_miss)));

   always_comb begin
      prdata = '0;
      if (is_entry) begin
         prdata[entry_valid_bit]  = entry_valid[entry_idx];
         prdata[num_ports-1:0]    = entry_mask[entry_idx];
      end else if (is_hit) begin
         prdata = hit_count;
      end else if (is_miss) begin
         prdata = miss_count;
      end
   end

   assign lookup_entry_valid = entry_valid[lookup_tag];
   assign lookup_mask        = entry_mask[lookup_tag];

   always_ff @(posedge clk) begin
      if (entry_wr)
         entry_mask[entry_idx] <= pwdata[num_ports-1:0];
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         entry_valid <= '0;
         hit_count   <= '0;
         miss_count  <= '0;
      end else begin
         if (entry_wr)
            entry_valid[entry_idx] <= pwdata[entry_valid_bit];
         // Both counters wrap
         if (count_hit)
            hit_count <= hit_count + 1'b1;
         if (count_miss)
            miss_count <= miss_count + 1'b1;
      end
   end

endmodule

//--- verilog/input_arbiter.sv
`timescale 1ns/100ps

module input_arbiter
   import of_switch_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,
   input  word_t                q_data [num_ports],
   input  ctrl_t                q_ctrl [num_ports],
   input  logic [num_ports-1:0] q_empty,
   output logic [num_ports-1:0] q_rd_en,
   output word_t                arb_data,
   output ctrl_t                arb_ctrl,
   output logic                 arb_wr,
   input  logic                 lut_rdy
);

   port_idx_t grant;
   port_idx_t sel;
   logic      in_pkt;
   logic      is_last;

   // ------------------------------------------------------------------------
   // Port selection
   // ------------------------------------------------------------------------
   // Inside a packet the grant is held. At a boundary the search starts
   // one past the last grant, so the nearest non-empty queue wins and the
   // old grant itself is tried last.
   always_comb begin
      sel = grant;
      if (!in_pkt) begin
         for (int i = num_ports; i >= 1; i--) begin
            if (!q_empty[port_idx_t'(grant + port_idx_t'(i))])
               sel = port_idx_t'(grant + port_idx_t'(i));
         end
      end
   end

   assign arb_wr   = !q_empty[sel] && lut_rdy;
   assign arb_ctrl = q_ctrl[sel];
   assign is_last  = (arb_ctrl != '0) && (arb_ctrl != ctrl_hdr);

   // Stamp source port into header words
   always_comb begin
      arb_data = q_data[sel];
      if (arb_ctrl == ctrl_hdr)
         arb_data[src_port_lsb +: $bits(port_idx_t)] = sel;
   end

   always_comb begin
      q_rd_en      = '0;
      q_rd_en[sel] = arb_wr;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         // Port 0 is first in line after reset
         grant  <= port_idx_t'(num_ports - 1);
         in_pkt <= 1'b0;
      end else if (arb_wr) begin
         grant  <= sel;
         in_pkt <= !is_last;
      end
   end

endmodule

//--- verilog/input_queue.sv
`timescale 1ns/100ps

module input_queue
   import of_switch_pkg::*;
(
   input  logic  clk,
   input  logic  rst_n,
   input  word_t in_data,
   input  ctrl_t in_ctrl,
   input  logic  in_wr,
   output logic  in_rdy,
   output word_t q_data,
   output ctrl_t q_ctrl,
   output logic  q_empty,
   input  logic  q_rd_en
);

   word_t data_mem [queue_depth];
   ctrl_t ctrl_mem [queue_depth];

   logic [queue_addr_width-1:0] wr_ptr;
   logic [queue_addr_width-1:0] rd_ptr;
   logic [queue_addr_width:0]   fill;
   logic                        push;
   logic                        pop;

   assign in_rdy  = (fill != queue_depth);
   assign q_empty = (fill == '0);
   assign push    = in_wr && in_rdy;
   assign pop     = q_rd_en && !q_empty;

   // Head word shown without a read cycle
   assign q_data = data_mem[rd_ptr];
   assign q_ctrl = ctrl_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push) begin
         data_mem[wr_ptr] <= in_data;
         ctrl_mem[wr_ptr] <= in_ctrl;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         fill   <= '0;
      end else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         // Simultaneous push and pop leaves the count alone
         if (push && !pop)
            fill <= fill + 1'b1;
         else if (pop && !push)
            fill <= fill - 1'b1;
      end
   end

endmodule

//--- verilog/of_switch_pkg.sv
package of_switch_pkg;

   // Datapath widths
   localparam int data_width = 64;
   localparam int ctrl_width = 8;
   localparam int num_ports  = 4;

   // Control value of a header word
   localparam logic [ctrl_width-1:0] ctrl_hdr = '1;

   // Header field positions
   localparam int flow_tag_lsb   = 0;
   localparam int flow_tag_width = 4;
   localparam int src_port_lsb   = 16;
   localparam int out_mask_lsb   = 24;

   localparam int table_depth      = 16;
   localparam int queue_depth      = 16;
   localparam int queue_addr_width = $clog2(queue_depth);

   // ------------------------------------------------------------------------
   // APB register map
   // ------------------------------------------------------------------------
   localparam int apb_addr_width  = 8;
   localparam int apb_data_width  = 32;
   localparam int entry_valid_bit = 4;
   localparam logic [apb_addr_width-1:0] entry_last_addr = 8'h3c;
   localparam logic [apb_addr_width-1:0] hit_count_addr  = 8'h40;
   localparam logic [apb_addr_width-1:0] miss_count_addr = 8'h44;

   typedef logic [data_width-1:0]        word_t;
   typedef logic [ctrl_width-1:0]        ctrl_t;
   typedef logic [$clog2(num_ports)-1:0] port_idx_t;
   typedef logic [num_ports-1:0]         port_mask_t;
   typedef logic [flow_tag_width-1:0]    flow_tag_t;

endpackage

//--- verilog/openflow_switch.sv
`timescale 1ns/100ps

module openflow_switch
   import of_switch_pkg::*;
(
   input  logic                      clk,
   input  logic                      rst_n,
   // Ingress ports
   input  word_t                     in_data [num_ports],
   input  ctrl_t                     in_ctrl [num_ports],
   input  logic [num_ports-1:0]      in_wr,
   output logic [num_ports-1:0]      in_rdy,
   // Egress ports
   output word_t                     out_data [num_ports],
   output ctrl_t                     out_ctrl [num_ports],
   output logic [num_ports-1:0]      out_wr,
   input  logic [num_ports-1:0]      out_rdy,
   // APB slave
   input  logic [apb_addr_width-1:0] paddr,
   input  logic                      psel,
   input  logic                      penable,
   input  logic                      pwrite,
   input  logic [apb_data_width-1:0] pwdata,
   output logic [apb_data_width-1:0] prdata,
   output logic                      pready,
   output logic                      pslverr
);

   // ------------------------------------------------------------------------
   // Internal links
   // ------------------------------------------------------------------------
   word_t                q_data [num_ports];
   ctrl_t                q_ctrl [num_ports];
   logic [num_ports-1:0] q_empty;
   logic [num_ports-1:0] q_rd_en;

   word_t      arb_data;
   ctrl_t      arb_ctrl;
   logic       arb_wr;
   logic       lut_rdy;

   word_t      lut_data;
   ctrl_t      lut_ctrl;
   logic       lut_wr;
   logic       demux_rdy;

   flow_tag_t  lookup_tag;
   logic       lookup_entry_valid;
   port_mask_t lookup_mask;
   logic       count_hit;
   logic       count_miss;

   // One queue per ingress port
   for (genvar p = 0; p < num_ports; p++) begin : g_queue
      input_queue u_input_queue (
         .clk     (clk),
         .rst_n   (rst_n),
         .in_data (in_data[p]),
         .in_ctrl (in_ctrl[p]),
         .in_wr   (in_wr[p]),
         .in_rdy  (in_rdy[p]),
         .q_data  (q_data[p]),
         .q_ctrl  (q_ctrl[p]),
         .q_empty (q_empty[p]),
         .q_rd_en (q_rd_en[p])
      );
   end

   input_arbiter u_input_arbiter (
      .clk      (clk),
      .rst_n    (rst_n),
      .q_data   (q_data),
      .q_ctrl   (q_ctrl),
      .q_empty  (q_empty),
      .q_rd_en  (q_rd_en),
      .arb_data (arb_data),
      .arb_ctrl (arb_ctrl),
      .arb_wr   (arb_wr),
      .lut_rdy  (lut_rdy)
   );

   flow_table u_flow_table (
      .clk                (clk),
      .rst_n              (rst_n),
      .paddr              (paddr),
      .psel               (psel),
      .penable            (penable),
      .pwrite             (pwrite),
      .pwdata             (pwdata),
      .prdata             (prdata),
      .pready             (pready),
      .pslverr            (pslverr),
      .lookup_tag         (lookup_tag),
      .lookup_entry_valid (lookup_entry_valid),
      .lookup_mask        (lookup_mask),
      .count_hit          (count_hit),
      .count_miss         (count_miss)
   );

   output_port_lookup u_output_port_lookup (
      .clk                (clk),
      .rst_n              (rst_n),
      .arb_data           (arb_data),
      .arb_ctrl           (arb_ctrl),
      .arb_wr             (arb_wr),
      .lut_rdy            (lut_rdy),
      .lookup_tag         (lookup_tag),
      .lookup_entry_valid (lookup_entry_valid),
      .lookup_mask        (lookup_mask),
      .count_hit          (count_hit),
      .count_miss         (count_miss),
      .lut_data           (lut_data),
      .lut_ctrl           (lut_ctrl),
      .lut_wr             (lut_wr),
      .demux_rdy          (demux_rdy)
   );

   egress_demux u_egress_demux (
      .clk       (clk),
      .rst_n     (rst_n),
      .lut_data  (lut_data),
      .lut_ctrl  (lut_ctrl),
      .lut_wr    (lut_wr),
      .demux_rdy (demux_rdy),
      .out_data  (out_data),
      .out_ctrl  (out_ctrl),
      .out_wr    (out_wr),
      .out_rdy   (out_rdy)
   );

endmodule

//--- verilog/output_port_lookup.sv
`timescale 1ns/100ps

module output_port_lookup
   import of_switch_pkg::*;
(
   input  logic       clk,
   input  logic       rst_n,
   input  word_t      arb_data,
   input  ctrl_t      arb_ctrl,
   input  logic       arb_wr,
   output logic       lut_rdy,
   output flow_tag_t  lookup_tag,
   input  logic       lookup_entry_valid,
   input  port_mask_t lookup_mask,
   output logic       count_hit,
   output logic       count_miss,
   output word_t      lut_data,
   output ctrl_t      lut_ctrl,
   output logic       lut_wr,
   input  logic       demux_rdy
);

   word_t stg_data;
   ctrl_t stg_ctrl;
   logic  stg_vld;
   logic  stg_hdr;
   logic  fwd;
   logic  drop_now;
   logic  stg_out;

   assign stg_hdr    = (stg_ctrl == ctrl_hdr);
   assign lookup_tag = stg_data[flow_tag_lsb +: flow_tag_width];

   // Header decides from the table, later words follow the latched decision
   assign drop_now = stg_hdr ? !(lookup_entry_valid && (|lookup_mask)) : !fwd;

   // Stage empties when its word is sent or thrown away
   assign stg_out = stg_vld && (drop_now || demux_rdy);
   assign lut_rdy = !stg_vld || stg_out;
   assign lut_wr  = stg_vld && !drop_now && demux_rdy;

   assign count_hit  = stg_out && stg_hdr && !drop_now;
   assign count_miss = stg_out && stg_hdr && drop_now;

   assign lut_ctrl = stg_ctrl;

   // Entry mask replaces the header mask field
   always_comb begin
      lut_data = stg_data;
      if (stg_hdr)
         lut_data[out_mask_lsb +: num_ports] = lookup_mask;
   end

   always_ff @(posedge clk) begin
      if (arb_wr) begin
         stg_data <= arb_data;
         stg_ctrl <= arb_ctrl;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stg_vld <= 1'b0;
         fwd     <= 1'b0;
      end else begin
         if (arb_wr)
            stg_vld <= 1'b1;
         else if (stg_out)
            stg_vld <= 1'b0;
         if (stg_out && stg_hdr)
            fwd <= !drop_now;
      end
   end

endmodule
